// File: egress_pkg.sv
/* Shared widths, port map and word types of the egress demultiplexer.
   The four-port map is fixed here; ports 4 to 7 are not present. */

`default_nettype none

package egress_pkg;

    //////////////////////////////////////////////////////////////////////
    // Sizes

    // Bytes per input word
    localparam int word_bytes = 8;

    // Words held by each port buffer
    localparam int fifo_depth = 16;

    // Physical ports
    localparam int num_ports = 4;

    // Lane width in bytes of each physical port, indexed by port number
    localparam int port_lane_bytes [num_ports] = '{1, 1, 4, 4};

    //////////////////////////////////////////////////////////////////////
    // Scalar types

    typedef logic [2:0]                port_id_t;     // 4 to 7 name no port
    typedef logic [word_bytes*8-1:0]   word_data_t;
    typedef logic [word_bytes-1:0]     word_keep_t;
    typedef logic [num_ports-1:0]      port_mask_t;   // One bit per port
    typedef logic [3:0]                fifo_ptr_t;
    typedef logic [4:0]                fifo_count_t;  // Holds 0 to fifo_depth
    typedef logic [3:0]                byte_count_t;  // Holds 0 to word_bytes
    typedef logic [31:0]               lane_data_t;
    typedef logic [3:0]                lane_keep_t;

    //////////////////////////////////////////////////////////////////////
    // Word and beat formats

    // Input word, port is only meaningful on the first word of a packet
    typedef struct packed {
        word_data_t data;
        word_keep_t keep;
        logic       last;
        port_id_t   port;
    } egress_word_t;

    // Buffered word, as stored per port
    typedef struct packed {
        word_data_t data;
        word_keep_t keep;
        logic       last;
    } buf_word_t;

    // Output beat; 8-bit ports use data[7:0] and keep[0] only
    typedef struct packed {
        lane_data_t data;
        lane_keep_t keep;
        logic       last;
    } lane_beat_t;

    //////////////////////////////////////////////////////////////////////
    // Control FSM

    typedef enum logic [1:0] {
        idle,
        route,
        discard
    } ctrl_state_e;

endpackage

`default_nettype wire

// File: egress_ctrl.sv
/* Routes each input packet to the buffer named by its first word.
   Invalid port numbers are accepted and dropped; never pushes into a full buffer. */

`timescale 1ns/1ns
`default_nettype none

module egress_ctrl (
    input  wire                      clk_ifc,
    input  wire                      rst_n,
    input  egress_pkg::egress_word_t in_word,
    input  wire                      in_valid,
    output logic                     in_ready,
    input  egress_pkg::port_mask_t   buf_full,
    output egress_pkg::port_mask_t   push,
    output egress_pkg::buf_word_t    push_word
);

    egress_pkg::ctrl_state_e state;
    egress_pkg::port_id_t    sel_port;
    egress_pkg::port_id_t    tgt;
    logic                    run;
    logic                    port_ok;
    logic                    xfer;

    // Port numbers at or above the port count are dropped
    assign port_ok = in_word.port < egress_pkg::port_id_t'(egress_pkg::num_ports);

    // First word picks its own port, later words follow the latched one
    assign tgt = (state == egress_pkg::idle) ? in_word.port : sel_port;

    always_comb begin
        push = '0;
        if (state == egress_pkg::discard ||
            (state == egress_pkg::idle && !port_ok)) begin
            in_ready = run;
        end else begin
            // Stall only on the buffer this packet goes to
            in_ready = run && !buf_full[tgt[1:0]];
            push[tgt[1:0]] = in_valid && in_ready;
        end
    end

    assign xfer = in_valid && in_ready;

    assign push_word.data = in_word.data;
    assign push_word.keep = in_word.keep;
    assign push_word.last = in_word.last;

    //////////////////////////////////////////////////////////////////////
    // Packet FSM

    always_ff @(posedge clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            state    <= egress_pkg::idle;
            sel_port <= '0;
            run      <= 1'b0;
        end else begin
            // Input opens one cycle after reset release
            run <= 1'b1;
            case (state)
                egress_pkg::idle: begin
                    // Single-word packets complete here without leaving idle
                    if (xfer && !in_word.last) begin
                        sel_port <= in_word.port;
                        state    <= port_ok ? egress_pkg::route : egress_pkg::discard;
                    end
                end
                egress_pkg::route, egress_pkg::discard: begin
                    if (xfer && in_word.last) begin
                        state <= egress_pkg::idle;
                    end
                end
                default: state <= egress_pkg::idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: egress_fifo.sv
/* Per-port word buffer, fifo_depth entries, head shown without read latency.
   Has no overflow guard; the writer must respect full. */

`timescale 1ns/1ns
`default_nettype none

module egress_fifo (
    input  wire                   clk_ifc,
    input  wire                   rst_n,
    input  wire                   push,
    input  egress_pkg::buf_word_t push_word,
    output logic                  full,
    input  wire                   pop,
    output egress_pkg::buf_word_t head,
    output logic                  not_empty
);

    egress_pkg::buf_word_t    mem [egress_pkg::fifo_depth];
    egress_pkg::fifo_ptr_t    wr_ptr;
    egress_pkg::fifo_ptr_t    rd_ptr;
    egress_pkg::fifo_count_t  count;
    logic                     do_pop;

    assign full      = count == egress_pkg::fifo_count_t'(egress_pkg::fifo_depth);
    assign not_empty = count != '0;
    assign head      = mem[rd_ptr];

    // A pop on an empty buffer is ignored
    assign do_pop = pop && not_empty;

    //////////////////////////////////////////////////////////////////////
    // Storage

    always_ff @(posedge clk_ifc) begin
        if (push) begin
            mem[wr_ptr] <= push_word;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Pointers and occupancy

    always_ff @(posedge clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // Pointers wrap naturally at 16 entries
            if (push) begin
                wr_ptr <= wr_ptr + egress_pkg::fifo_ptr_t'(1);
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + egress_pkg::fifo_ptr_t'(1);
            end
            case ({push, do_pop})
                2'b10:   count <= count + egress_pkg::fifo_count_t'(1);
                2'b01:   count <= count - egress_pkg::fifo_count_t'(1);
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: egress_width_conv.sv
/* Splits each buffered 64-bit word into lanes of lane_bytes (1, 2 or 4).
   Expects keep contiguous from byte 0 and non-zero. */

`timescale 1ns/1ns
`default_nettype none

module egress_width_conv #(
    parameter int lane_bytes = 4
) (
    input  wire                    clk_ifc,
    input  wire                    rst_n,
    input  egress_pkg::buf_word_t  head,
    input  wire                    not_empty,
    output logic                   pop,
    output egress_pkg::lane_beat_t beat,
    output logic                   beat_valid,
    input  wire                    beat_ready
);

    egress_pkg::buf_word_t   word_r;
    egress_pkg::byte_count_t offset;
    egress_pkg::byte_count_t nbytes;
    egress_pkg::byte_count_t remaining;
    egress_pkg::word_data_t  shifted;
    logic                    loaded;
    logic                    is_final;

    // Bytes of the loaded word not yet sent
    assign remaining = nbytes - offset;
    assign is_final  = remaining <= egress_pkg::byte_count_t'(lane_bytes);

    // Next word loads when idle, or as the last lane of this one leaves
    assign pop = not_empty && (!loaded || (beat_ready && is_final));

    assign beat_valid = loaded;
    assign shifted    = word_r.data >> {offset, 3'b000};

    //////////////////////////////////////////////////////////////////////
    // Beat formatting

    always_comb begin
        beat      = '0;
        beat.data = egress_pkg::lane_data_t'(shifted[lane_bytes*8-1:0]);
        for (int i = 0; i < lane_bytes; i++) begin
            // Partial final lane keeps only the bytes that remain
            beat.keep[i] = egress_pkg::byte_count_t'(i) < remaining;
        end
        beat.last = word_r.last && is_final;
    end

    //////////////////////////////////////////////////////////////////////
    // Word register

    always_ff @(posedge clk_ifc) begin
        if (pop) begin
            word_r <= head;
            nbytes <= egress_pkg::byte_count_t'($countones(head.keep));
        end
    end

    always_ff @(posedge clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            loaded <= 1'b0;
            offset <= '0;
        end else begin
            if (pop) begin
                loaded <= 1'b1;
                offset <= '0;
            end else if (loaded && beat_ready) begin
                if (is_final) begin
                    loaded <= 1'b0;
                end else begin
                    offset <= offset + egress_pkg::byte_count_t'(lane_bytes);
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: mpls_egress.sv
/* Egress demultiplexer top: one 64-bit input, ports 0-1 are 8-bit, 2-3 are 32-bit.
   Unused upper lanes of the 8-bit ports are driven to zero. */

`timescale 1ns/1ns
`default_nettype none

module mpls_egress (
    input  wire                                                 clk_ifc,
    input  wire                                                 rst_n,
    input  egress_pkg::egress_word_t                            in_word,
    input  wire                                                 in_valid,
    output logic                                                in_ready,
    output egress_pkg::lane_beat_t [egress_pkg::num_ports-1:0]  out_beat,
    output egress_pkg::port_mask_t                              out_valid,
    input  egress_pkg::port_mask_t                              out_ready
);

    egress_pkg::port_mask_t                              fifo_push;
    egress_pkg::port_mask_t                              fifo_full;
    egress_pkg::port_mask_t                              fifo_not_empty;
    egress_pkg::port_mask_t                              fifo_pop;
    egress_pkg::buf_word_t                               push_word;
    egress_pkg::buf_word_t [egress_pkg::num_ports-1:0]   fifo_head;

    //////////////////////////////////////////////////////////////////////
    // Packet steering

    egress_ctrl ctrl0 (
        .clk_ifc   (clk_ifc),
        .rst_n     (rst_n),
        .in_word   (in_word),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .buf_full  (fifo_full),
        .push      (fifo_push),
        .push_word (push_word)
    );

    //////////////////////////////////////////////////////////////////////
    // Per-port buffer and serializer

    for (genvar p = 0; p < egress_pkg::num_ports; p++) begin : g_port
        egress_fifo fifo0 (
            .clk_ifc   (clk_ifc),
            .rst_n     (rst_n),
            .push      (fifo_push[p]),
            .push_word (push_word),
            .full      (fifo_full[p]),
            .pop       (fifo_pop[p]),
            .head      (fifo_head[p]),
            .not_empty (fifo_not_empty[p])
        );

        egress_width_conv #(
            .lane_bytes (egress_pkg::port_lane_bytes[p])
        ) conv0 (
            .clk_ifc    (clk_ifc),
            .rst_n      (rst_n),
            .head       (fifo_head[p]),
            .not_empty  (fifo_not_empty[p]),
            .pop        (fifo_pop[p]),
            .beat       (out_beat[p]),
            .beat_valid (out_valid[p]),
            .beat_ready (out_ready[p])
        );
    end

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
/* 20 ns clock; rst_n held low for 4 cycles and released on a falling edge. */

`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
    output logic clk_ifc,
    output logic rst_n
);

    initial begin
        clk_ifc = 1'b0;
        forever #10 clk_ifc = ~clk_ifc;
    end

    initial begin
        rst_n = 1'b0;
        repeat (4) @(posedge clk_ifc);
        @(negedge clk_ifc);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: tb_egress_assertions.sv
/* Handshake and routing checks on the packet controller.
   Bound to every egress_ctrl instance. */

`timescale 1ns/1ns
`default_nettype none

module tb_egress_assertions (
    input wire                    clk_ifc,
    input wire                    rst_n,
    input wire                    in_ready,
    input egress_pkg::port_mask_t buf_full,
    input egress_pkg::port_mask_t push
);

    // One buffer at most per transferred word
    push_onehot: assert property (@(posedge clk_ifc) disable iff (!rst_n) $onehot0(push))
        else $error("push not one-hot: %b", push);

    no_push_when_full: assert property (@(posedge clk_ifc) disable iff (!rst_n)
        (push & buf_full) == '0)
        else $error("push %b into full buffer %b", push, buf_full);

    ready_low_in_reset: assert property (@(posedge clk_ifc) !rst_n |-> !in_ready)
        else $error("in_ready high during reset");

endmodule

bind egress_ctrl tb_egress_assertions asrt0 (
    .clk_ifc  (clk_ifc),
    .rst_n    (rst_n),
    .in_ready (in_ready),
    .buf_full (buf_full),
    .push     (push)
);

`default_nettype wire

// File: tb_mpls_egress.sv
/* Directed testbench for mpls_egress. Packet byte i carries i mod 256,
   and bytes past the end of a packet are driven as zero. */

`timescale 1ns/1ns
`default_nettype none

module tb_mpls_egress;

    logic                                               clk_ifc;
    logic                                               rst_n;
    egress_pkg::egress_word_t                           in_word;
    logic                                               in_valid;
    logic                                               in_ready;
    egress_pkg::lane_beat_t [egress_pkg::num_ports-1:0] out_beat;
    egress_pkg::port_mask_t                             out_valid;
    egress_pkg::port_mask_t                             out_ready = '0;

    // Expected packet lengths and bytes received so far, per port
    int                     exp_len  [egress_pkg::num_ports][$];
    logic [7:0]             rx_bytes [egress_pkg::num_ports][$];
    egress_pkg::port_id_t   last_sent_port = '0;
    egress_pkg::port_mask_t hold_low = '0;
    bit                     random_bp = 1'b0;
    bit                     verdict_printed = 1'b0;
    int                     stall_cycles = 0;
    int                     watch_cycles = 0;
    int                     lens [56];

    tb_clock_gen clk0 (
        .clk_ifc (clk_ifc),
        .rst_n   (rst_n)
    );

    mpls_egress dut0 (
        .clk_ifc   (clk_ifc),
        .rst_n     (rst_n),
        .in_word   (in_word),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_beat  (out_beat),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    task automatic abort_run(input string why);
        verdict_printed = 1'b1;
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic check_beat(input int port, input egress_pkg::lane_beat_t got,
                              input egress_pkg::lane_beat_t exp);
        if (got !== exp) begin
            abort_run($sformatf("Error: out_beat[%0d] = %h, expected %h", port, got, exp));
        end
    endtask

    task automatic check_port(input egress_pkg::port_id_t got, input egress_pkg::port_id_t exp);
        if (got !== exp) begin
            abort_run($sformatf("Error: out_valid port = %h, expected %h", got, exp));
        end
    endtask

    // Beat at byte pos of a packet; lanes never cross a 64-bit word
    function automatic egress_pkg::lane_beat_t expect_beat(input int len, input int pos,
                                                           input int lb);
        egress_pkg::lane_beat_t e;
        int word_left;
        int n;
        e = '0;
        word_left = len - (pos / 8) * 8;
        if (word_left > 8) begin
            word_left = 8;
        end
        word_left = word_left - pos % 8;
        n = (word_left < lb) ? word_left : lb;
        for (int k = 0; k < n; k++) begin
            e.data[8*k +: 8] = 8'((pos + k) % 256);
            e.keep[k] = 1'b1;
        end
        e.last = (pos + n) == len;
        return e;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Output sinks and ready drivers

    task automatic take_beat(input int p, input egress_pkg::lane_beat_t b);
        int lb;
        int bad;
        lb = egress_pkg::port_lane_bytes[p];
        bad = -1;
        if (exp_len[p].size() == 0) begin
            // A stray beat away from the last addressed port is a misroute
            check_port(egress_pkg::port_id_t'(p), last_sent_port);
            abort_run($sformatf("Beat arrived on port %0d with no packet pending", p));
        end else begin
            check_beat(p, b, expect_beat(exp_len[p][0], rx_bytes[p].size(), lb));
            for (int k = 0; k < lb; k++) begin
                if (b.keep[k]) begin
                    rx_bytes[p].push_back(b.data[8*k +: 8]);
                end
            end
            if (b.last) begin
                for (int i = 0; i < rx_bytes[p].size(); i++) begin
                    if (bad < 0 && rx_bytes[p][i] !== 8'(i % 256)) begin
                        bad = i;
                    end
                end
                if (rx_bytes[p].size() != exp_len[p][0]) begin
                    abort_run($sformatf("Packet on port %0d has %0d bytes, expected %0d",
                                        p, rx_bytes[p].size(), exp_len[p][0]));
                end else if (bad >= 0) begin
                    abort_run($sformatf("Error: port %0d byte %0d = %h, expected %h",
                                        p, bad, rx_bytes[p][bad], 8'(bad % 256)));
                end else begin
                    exp_len[p].pop_front();
                    rx_bytes[p].delete();
                end
            end
        end
    endtask

    always @(posedge clk_ifc) begin
        for (int p = 0; p < egress_pkg::num_ports; p++) begin
            if (rst_n && out_valid[p] && out_ready[p]) begin
                take_beat(p, out_beat[p]);
            end
        end
    end

    always @(negedge clk_ifc) begin
        if (random_bp) begin
            out_ready = egress_pkg::port_mask_t'($urandom);
        end else begin
            out_ready = ~hold_low;
        end
    end

    // Takes effect at the next falling edge
    task automatic set_ready_mode(input bit rnd, input egress_pkg::port_mask_t hold);
        @(posedge clk_ifc);
        random_bp = rnd;
        hold_low  = hold;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Input driver

    task automatic send_packet(input int port, input int len);
        egress_pkg::egress_word_t w;
        int nwords;
        nwords = (len + 7) / 8;
        last_sent_port = egress_pkg::port_id_t'(port);
        if (port < egress_pkg::num_ports) begin
            exp_len[port].push_back(len);
        end
        for (int i = 0; i < nwords; i++) begin
            w = '0;
            w.port = egress_pkg::port_id_t'(port);
            w.last = (i == nwords - 1);
            for (int k = 0; k < 8; k++) begin
                if (8*i + k < len) begin
                    w.data[8*k +: 8] = 8'((8*i + k) % 256);
                    w.keep[k] = 1'b1;
                end
            end
            @(negedge clk_ifc);
            in_word  = w;
            in_valid = 1'b1;
            @(posedge clk_ifc);
            while (!in_ready) begin
                stall_cycles++;
                @(posedge clk_ifc);
            end
        end
        @(negedge clk_ifc);
        in_valid = 1'b0;
    endtask

    task automatic wait_drained();
        int pending;
        do begin
            @(negedge clk_ifc);
            pending = 0;
            for (int p = 0; p < egress_pkg::num_ports; p++) begin
                pending += exp_len[p].size();
            end
        end while (pending != 0);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Directed tests

    task automatic test_routing();
        for (int i = 0; i < 40; i++) begin
            send_packet(i % 4, lens[i]);
            wait_drained();
        end
    endtask

    task automatic test_lengths();
        int short_lens [5] = '{1, 7, 8, 9, 13};
        for (int p = 0; p < egress_pkg::num_ports; p++) begin
            for (int j = 0; j < 5; j++) begin
                send_packet(p, short_lens[j]);
                wait_drained();
            end
        end
    endtask

    task automatic test_backpressure();
        set_ready_mode(1'b1, '0);
        for (int i = 0; i < 12; i++) begin
            send_packet(i % 4, lens[40 + i]);
        end
        wait_drained();
        set_ready_mode(1'b0, '0);
    endtask

    // Ports 5 and 7 do not exist, so those packets must vanish
    task automatic test_discard();
        send_packet(5, lens[52]);
        send_packet(1, lens[53]);
        send_packet(7, lens[54]);
        send_packet(2, lens[55]);
        wait_drained();
        repeat (30) @(negedge clk_ifc);
    endtask

    task automatic test_port_stall();
        int start;
        int waited;
        start  = stall_cycles;
        waited = 0;
        set_ready_mode(1'b0, 4'b0100);
        fork
            begin
                send_packet(0, 64);
                send_packet(2, 200);
                send_packet(0, 40);
                send_packet(2, 40);
            end
            begin
                while (stall_cycles - start < 10 && waited < 1000) begin
                    @(negedge clk_ifc);
                    waited++;
                end
                if (stall_cycles - start < 10) begin
                    abort_run("in_ready never dropped while port 2 was blocked");
                end else begin
                    set_ready_mode(1'b0, '0);
                end
            end
        join
        wait_drained();
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence and watchdog

    initial begin
        int total;
        void'($urandom(32'hb336f422));
        in_word  = '0;
        in_valid = 1'b0;
        // Fixed lengths of the short-packet and stall tests
        total = 152 + 344;
        for (int i = 0; i < 56; i++) begin
            lens[i] = (i < 40) ? $urandom_range(300, 64) :
                      (i < 52) ? $urandom_range(120, 1) : $urandom_range(60, 9);
            total += lens[i];
        end
        watch_cycles = total * 40 + 2000;
        @(posedge rst_n);
        test_routing();
        test_lengths();
        test_backpressure();
        test_discard();
        test_port_stall();
        verdict_printed = 1'b1;
        $display("TB PASSED");
        $finish;
    end

    initial begin
        wait (watch_cycles != 0);
        repeat (watch_cycles) @(posedge clk_ifc);
        abort_run($sformatf("Timeout after %0d cycles, traffic stopped", watch_cycles));
    end

    // Covers a run stopped by a failing assertion
    final begin
        if (!verdict_printed) begin
            $display("TB FAILED");
        end
    end

endmodule

`default_nettype wire

// File: flist.f
egress_pkg.sv
egress_ctrl.sv
egress_fifo.sv
egress_width_conv.sv
mpls_egress.sv
tb_clock_gen.sv
tb_egress_assertions.sv
tb_mpls_egress.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_mpls_egress
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "TB PASSED" $(LOG); then echo "Simulation ended without a verdict"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
